// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= pipeTb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== ctrlPkg.sv ====
package ctrlPkg;

    // Instruction bus master.
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        DRAIN    // Finishing a cycle opened before a redirect.
    } fetchState_t;

    // Multiply hold in E.
    typedef enum logic {
        RUN,
        WAIT
    } execState_t;

endpackage

// ==== execBackend.sv ====
`include "pipe_defs.svh"

module execBackend (
    input  logic clk,
    input  logic reset,
    pipeCtrlIf.backSide ctrl,
    input  logic issueValid,
    input  instrPkg::pc_t issuePc,
    input  instrPkg::instr_t issueInstr,
    output logic eWait,
    output logic dWait,
    output logic branchM,
    output logic excpM,
    output logic excpW,
    output logic redirectValid,
    output instrPkg::pc_t redirectPc,
    output instrPkg::operand_t dAdr,
    input  instrPkg::data_t dDatIn,
    output logic dCyc,
    output logic dStb,
    input  logic dAck,
    output logic retireValid,
    output instrPkg::pc_t retirePc,
    output instrPkg::data_t retireData
);
    ctrlPkg::execState_t eState;
    logic [3:0] mulCnt;
    logic eValid, mValid, m2Valid, m3Valid, wValid;
    instrPkg::pc_t ePc, mPc, m2Pc, m3Pc, wPc;
    instrPkg::instr_t eInstr, mInstr;
    instrPkg::kind_t issueKind, mKind, m2Kind, m3Kind, wKind;
    instrPkg::data_t m2Data, m3Data, wData;
    logic loadM;
    logic orphanValid;
    instrPkg::operand_t orphanAdr;

    assign issueKind = issueInstr[15:13];
    assign mKind = mInstr[15:13];
    assign loadM = mValid && mKind == instrPkg::KIND_LOAD;

    assign eWait = eState == ctrlPkg::WAIT;
    assign branchM = mValid && mKind == instrPkg::KIND_BRANCH;
    assign excpM = mValid && mKind == instrPkg::KIND_TRAPM;
    assign excpW = wValid && wKind == instrPkg::KIND_TRAPW;
    assign redirectValid = branchM || excpM || excpW;
    assign redirectPc = (excpM || excpW) ? instrPkg::pc_t'(`EXCP_VECTOR) : mInstr[12:0];

    // A load killed mid-cycle keeps the bus until its ack.
    assign dCyc = loadM || orphanValid;
    assign dStb = dCyc;
    assign dAdr = orphanValid ? orphanAdr : mInstr[12:0];
    assign dWait = loadM && (orphanValid || !dAck);

    always_ff @(posedge clk) begin
        if (reset) begin
            orphanValid <= 1'b0;
        end else if (orphanValid) begin
            if (dAck) orphanValid <= 1'b0;
        end else if (loadM && !dAck && ctrl.flushM2) begin
            orphanValid <= 1'b1;
            orphanAdr <= mInstr[12:0];
        end
    end

    // Multiply holds E for count plus one cycles.
    always_ff @(posedge clk) begin
        if (reset || ctrl.flushE) begin
            eState <= ctrlPkg::RUN;
            mulCnt <= '0;
        end else if (eState == ctrlPkg::RUN) begin
            if (!ctrl.stallE && issueValid && issueKind == instrPkg::KIND_MUL) begin
                eState <= ctrlPkg::WAIT;
                mulCnt <= issueInstr[3:0];
            end
        end else if (mulCnt == 0) begin
            eState <= ctrlPkg::RUN;
        end else begin
            mulCnt <= mulCnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || ctrl.flushE) begin
            eValid <= 1'b0;
        end else if (!ctrl.stallE) begin
            eValid <= issueValid;
            ePc <= issuePc;
            eInstr <= issueInstr;
        end
        if (reset || ctrl.flushM) begin
            mValid <= 1'b0;
        end else if (!ctrl.stallM) begin
            mValid <= eValid;
            mPc <= ePc;
            mInstr <= eInstr;
        end
        if (reset || ctrl.flushM2) begin
            m2Valid <= 1'b0;
        end else if (!ctrl.stallM2) begin
            m2Valid <= mValid && mKind != instrPkg::KIND_TRAPM;    // TRAPM dies here.
            m2Pc <= mPc;
            m2Kind <= mKind;
            m2Data <= loadM ? dDatIn : '0;
        end
        if (reset || ctrl.flushM3) begin
            m3Valid <= 1'b0;
        end else begin
            m3Valid <= m2Valid;
            m3Pc <= m2Pc;
            m3Kind <= m2Kind;
            m3Data <= m2Data;
        end
        if (reset || ctrl.flushW) begin
            wValid <= 1'b0;
        end else begin
            wValid <= m3Valid;
            wPc <= m3Pc;
            wKind <= m3Kind;
            wData <= m3Data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retireValid <= 1'b0;
        end else begin
            retireValid <= wValid && wKind != instrPkg::KIND_TRAPW;
        end
        retirePc <= wPc;
        retireData <= wData;
    end

endmodule

// ==== fetchUnit.sv ====
`include "pipe_defs.svh"

module fetchUnit (
    input  logic clk,
    input  logic reset,
    pipeCtrlIf.frontSide ctrl,
    input  logic redirectValid,
    input  instrPkg::pc_t redirectPc,
    output instrPkg::pc_t iAdr,
    input  instrPkg::instr_t iDatIn,
    output logic iCyc,
    output logic iStb,
    input  logic iAck,
    output logic iWait,
    output logic fetchValid,
    output instrPkg::pc_t fetchPc,
    output instrPkg::instr_t fetchInstr
);
    ctrlPkg::fetchState_t state;
    instrPkg::pc_t pc;
    instrPkg::pc_t nextPc;
    instrPkg::pc_t bufPc;
    instrPkg::instr_t bufInstr;
    logic bufValid;
    logic capture;

    assign iCyc = state != ctrlPkg::IDLE;
    assign iStb = iCyc;
    assign iAdr = pc;
    assign iWait = iCyc && !iAck;
    assign capture = state == ctrlPkg::REQ && iAck;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ctrlPkg::IDLE;
            pc <= instrPkg::pc_t'(`RESET_PC);
        end else if (redirectValid) begin
            if (iWait) begin    // Address must hold until ack.
                nextPc <= redirectPc;
                state <= ctrlPkg::DRAIN;
            end else begin
                pc <= redirectPc;
                state <= ctrlPkg::IDLE;
            end
        end else begin
            case (state)
                ctrlPkg::IDLE: begin
                    if (!ctrl.stallF && !bufValid) state <= ctrlPkg::REQ;
                end
                ctrlPkg::REQ: begin
                    if (iAck) begin
                        pc <= pc + 1'b1;
                        state <= ctrl.stallF ? ctrlPkg::IDLE : ctrlPkg::REQ;
                    end
                end
                default: begin    // DRAIN drops the returned word.
                    if (iAck) begin
                        pc <= nextPc;
                        state <= ctrlPkg::IDLE;
                    end
                end
            endcase
        end
    end

    // F2 register with one spare slot for a word acked under stall.
    always_ff @(posedge clk) begin
        if (reset || ctrl.flushF2) begin
            fetchValid <= 1'b0;
            bufValid <= 1'b0;
        end else if (!ctrl.stallF2) begin
            fetchValid <= bufValid || capture;
            fetchPc <= bufValid ? bufPc : pc;
            fetchInstr <= bufValid ? bufInstr : iDatIn;
            bufValid <= 1'b0;
        end else if (capture) begin
            bufValid <= 1'b1;
            bufPc <= pc;
            bufInstr <= iDatIn;
        end
    end

endmodule

// ==== hazard.sv ====
module hazard (
    input  logic clk,
    input  logic reset,
    input  logic iWait,
    input  logic dWait,
    input  logic eWait,
    input  logic overflowI,
    input  logic branchM,
    input  logic excpM,
    input  logic excpW,
    pipeCtrlIf.hazardSide ctrl
);
    logic excpIwait;
    logic excpIwaitNext;
    logic branchIwait;
    logic branchIwaitNext;

    always_ff @(posedge clk) begin
        if (reset) begin
            excpIwait <= 1'b0;
            branchIwait <= 1'b0;
        end else begin
            excpIwait <= excpIwaitNext;
            branchIwait <= branchIwaitNext;
        end
    end

    always_comb begin
        ctrl.stallF = 1'b0;
        ctrl.stallF2 = 1'b0;
        ctrl.stallD = 1'b0;
        ctrl.stallI = 1'b0;
        ctrl.stallIde = 1'b0;
        ctrl.stallE = 1'b0;
        ctrl.stallM = 1'b0;
        ctrl.stallM2 = 1'b0;
        ctrl.flushF2 = 1'b0;
        ctrl.flushD = 1'b0;
        ctrl.flushI = 1'b0;
        ctrl.flushQue = 1'b0;
        ctrl.flushE = 1'b0;
        ctrl.flushM = 1'b0;
        ctrl.flushM2 = 1'b0;
        ctrl.flushM3 = 1'b0;
        ctrl.flushW = 1'b0;
        excpIwaitNext = excpIwait;
        branchIwaitNext = branchIwait;
        if (excpM || excpW) begin
            ctrl.flushF2 = 1'b1;
            ctrl.flushD = 1'b1;
            ctrl.flushI = 1'b1;
            ctrl.flushQue = 1'b1;
            ctrl.flushE = 1'b1;
            ctrl.flushM = 1'b1;
            if (excpW) begin    // Kill everything younger than the trap in W.
                ctrl.flushM2 = 1'b1;
                ctrl.flushM3 = 1'b1;
                ctrl.flushW = 1'b1;
            end
            if (iWait) begin
                excpIwaitNext = 1'b1;
                ctrl.stallF = 1'b1;
            end
        end else if (dWait) begin    // Whole pipe waits on the data bus.
            ctrl.stallF = 1'b1;
            ctrl.stallF2 = 1'b1;
            ctrl.stallD = 1'b1;
            ctrl.stallI = 1'b1;
            ctrl.stallIde = 1'b1;
            ctrl.stallE = 1'b1;
            ctrl.stallM = 1'b1;
            ctrl.stallM2 = 1'b1;
            ctrl.flushM3 = 1'b1;
        end else if (branchM) begin
            ctrl.flushF2 = 1'b1;
            ctrl.flushD = 1'b1;
            ctrl.flushI = 1'b1;
            ctrl.flushQue = 1'b1;
            ctrl.flushE = 1'b1;
            ctrl.flushM = 1'b1;
            if (iWait) begin
                branchIwaitNext = 1'b1;
                ctrl.stallF = 1'b1;
            end
        end else if (eWait) begin
            ctrl.stallF = 1'b1;
            ctrl.stallF2 = 1'b1;
            ctrl.stallD = 1'b1;
            ctrl.stallI = 1'b1;
            ctrl.stallIde = 1'b1;
            ctrl.stallE = 1'b1;
            ctrl.flushM = 1'b1;    // Bubbles behind the multiply.
        end else if (overflowI) begin
            ctrl.stallF = 1'b1;
            ctrl.stallF2 = 1'b1;
            ctrl.stallD = 1'b1;
            ctrl.stallI = 1'b1;
        end else if (iWait) begin
            ctrl.stallF = 1'b1;
            ctrl.flushF2 = 1'b1;
        end
        // Stale word from before the redirect arrives now.
        if (!ctrl.stallF && (excpIwait || branchIwait)) begin
            ctrl.flushF2 = 1'b1;
            ctrl.flushD = 1'b1;
            excpIwaitNext = 1'b0;
            branchIwaitNext = 1'b0;
        end
    end

endmodule

// ==== instrPkg.sv ====
`include "pipe_defs.svh"

package instrPkg;

    typedef logic [`PC_WIDTH-1:0] pc_t;
    typedef logic [15:0] instr_t;    // Kind in [15:13] and operand below.
    typedef logic [2:0] kind_t;
    typedef logic [12:0] operand_t;    // Branch target or load address.
    typedef logic [`DATA_WIDTH-1:0] data_t;

    localparam kind_t KIND_ALU = 3'd0;
    localparam kind_t KIND_BRANCH = 3'd1;
    localparam kind_t KIND_MUL = 3'd2;    // Operand [3:0] is the wait count.
    localparam kind_t KIND_LOAD = 3'd3;
    localparam kind_t KIND_TRAPM = 3'd4;
    localparam kind_t KIND_TRAPW = 3'd5;

endpackage

// ==== instrQueue.sv ====
`include "pipe_defs.svh"

module instrQueue (
    input  logic clk,
    input  logic reset,
    pipeCtrlIf.queueSide ctrl,
    input  logic fetchValid,
    input  instrPkg::pc_t fetchPc,
    input  instrPkg::instr_t fetchInstr,
    output logic overflowI,
    output logic issueValid,
    output instrPkg::pc_t issuePc,
    output instrPkg::instr_t issueInstr
);
    localparam int ptrBits = $clog2(`QUEUE_DEPTH);

    logic decValid;
    instrPkg::pc_t decPc;
    instrPkg::instr_t decInstr;
    instrPkg::pc_t qPc [`QUEUE_DEPTH];
    instrPkg::instr_t qInstr [`QUEUE_DEPTH];
    logic [ptrBits-1:0] head;
    logic [ptrBits-1:0] tail;
    logic [ptrBits:0] count;
    logic push;
    logic pop;

    // stallI holds the push side, stallIde the pop side.
    assign push = decValid && !ctrl.stallI && !ctrl.flushQue;
    assign pop = count != 0 && !ctrl.stallIde;
    assign overflowI = count >= `QUEUE_DEPTH - 1;    // One slot left for D.

    always_ff @(posedge clk) begin
        if (reset || ctrl.flushD) begin
            decValid <= 1'b0;
        end else if (!ctrl.stallD) begin
            decValid <= fetchValid;
            decPc <= fetchPc;
            decInstr <= fetchInstr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || ctrl.flushQue) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (push) tail <= tail + 1'b1;    // Wraps at depth.
            if (pop) head <= head + 1'b1;
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            qPc[tail] <= decPc;
            qInstr[tail] <= decInstr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || ctrl.flushI) begin
            issueValid <= 1'b0;
        end else if (!ctrl.stallIde) begin
            issueValid <= count != 0;    // Bubble when empty.
            issuePc <= qPc[head];
            issueInstr <= qInstr[head];
        end
    end

endmodule

// ==== pipeCtrlIf.sv ====
interface pipeCtrlIf;
    logic stallF;
    logic stallF2;
    logic stallD;
    logic stallI;    // Queue input side.
    logic stallIde;    // Queue output side.
    logic stallE;
    logic stallM;
    logic stallM2;
    logic flushF2;
    logic flushD;
    logic flushI;
    logic flushQue;
    logic flushE;
    logic flushM;
    logic flushM2;
    logic flushM3;
    logic flushW;

    modport hazardSide (
        output stallF, stallF2, stallD, stallI, stallIde, stallE, stallM, stallM2,
        output flushF2, flushD, flushI, flushQue, flushE, flushM, flushM2, flushM3, flushW
    );

    modport frontSide (input stallF, stallF2, flushF2);

    modport queueSide (input stallD, flushD, stallI, stallIde, flushI, flushQue);

    modport backSide (input stallE, flushE, stallM, flushM, stallM2, flushM2, flushM3, flushW);

endinterface

// ==== pipeTb.sv ====
`include "pipe_defs.svh"

module pipeTb;
    logic clk;
    logic reset;
    instrPkg::pc_t iAdr;
    instrPkg::instr_t iDatIn;
    logic iCyc;
    logic iStb;
    logic iAck;
    instrPkg::operand_t dAdr;
    instrPkg::data_t dDatIn;
    logic dCyc;
    logic dStb;
    logic dAck;
    logic retireValid;
    instrPkg::pc_t retirePc;
    instrPkg::data_t retireData;

    instrPkg::instr_t imem [2**`PC_WIDTH];
    instrPkg::pc_t expPc [$];
    instrPkg::data_t expData [$];
    int cycleLimit;
    int cycles;
    int retired;

    pipeTop dut (
        .clk(clk), .reset(reset),
        .iAdr(iAdr), .iDatIn(iDatIn), .iCyc(iCyc), .iStb(iStb), .iAck(iAck),
        .dAdr(dAdr), .dDatIn(dDatIn), .dCyc(dCyc), .dStb(dStb), .dAck(dAck),
        .retireValid(retireValid), .retirePc(retirePc), .retireData(retireData)
    );

    // Taps 17 and 14.
    function automatic logic [16:0] lfsrNext(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    // Two bits give 0 to 3 wait cycles.
    task automatic drawWait(inout logic [16:0] lfsr, output int waits);
        waits = 0;
        repeat (2) begin
            lfsr = lfsrNext(lfsr);
            waits = (waits << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic failRun(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkStrobe(
        input string name,
        input logic expected,
        input logic actual
    );
        if (actual !== expected) begin
            failRun($sformatf("** Error: %s expected %b actual %b", name, expected, actual));
        end
    endtask

    task automatic checkPc(
        input string name,
        input instrPkg::pc_t expected,
        input instrPkg::pc_t actual
    );
        if (actual !== expected) begin
            failRun($sformatf("** Error: %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic checkData(
        input string name,
        input instrPkg::data_t expected,
        input instrPkg::data_t actual
    );
        if (actual !== expected) begin
            failRun($sformatf("** Error: %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic loadStim();
        int fd;
        int fields;
        string line;
        logic [31:0] first;
        logic [31:0] second;
        for (int a = 0; a < 2**`PC_WIDTH; a++) begin
            imem[a] = instrPkg::instr_t'(a);    // ALU with the address as operand.
        end
        fd = $fopen("pipe_stim.txt", "r");
        if (fd == 0) begin
            failRun("cannot open the stimulus file pipe_stim.txt");
        end
        while ($fgets(line, fd) != 0) begin
            first = '0;
            second = '0;
            fields = $sscanf(line.substr(2, line.len() - 1), "%h %h", first, second);
            if (line.getc(0) == "M") begin
                if (fields != 2) failRun($sformatf("bad memory line: %s", line));
                imem[first[`PC_WIDTH-1:0]] = second[15:0];
            end else if (line.getc(0) == "R") begin
                if (fields != 2) failRun($sformatf("bad expected line: %s", line));
                expPc.push_back(instrPkg::pc_t'(first));
                expData.push_back(instrPkg::data_t'(second));
            end
        end
        $fclose(fd);
        if (expPc.size() == 0) begin
            failRun("the stimulus file holds no expected retirements");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Instruction memory slave.
    initial begin : instrSlave
        logic [16:0] lfsr;
        int waits;
        logic busy;
        lfsr = 17'd73183;
        waits = 0;
        busy = 1'b0;
        iAck = 1'b0;
        iDatIn = '0;
        forever begin
            @(posedge clk);
            #2;
            if (iAck) busy = 1'b0;    // Cycle ended on this edge.
            iAck = 1'b0;
            if (iCyc && iStb) begin
                if (!busy) begin
                    busy = 1'b1;
                    drawWait(lfsr, waits);
                end
                if (waits == 0) begin
                    iAck = 1'b1;
                    iDatIn = imem[iAdr];
                end else begin
                    waits--;
                end
            end else begin
                busy = 1'b0;
            end
        end
    end

    // Data memory slave.
    initial begin : dataSlave
        logic [16:0] lfsr;
        int waits;
        logic busy;
        lfsr = 17'd73183;
        waits = 0;
        busy = 1'b0;
        dAck = 1'b0;
        dDatIn = '0;
        forever begin
            @(posedge clk);
            #2;
            if (dAck) busy = 1'b0;
            dAck = 1'b0;
            if (dCyc && dStb) begin
                if (!busy) begin
                    busy = 1'b1;
                    drawWait(lfsr, waits);
                end
                if (waits == 0) begin
                    dAck = 1'b1;
                    dDatIn = instrPkg::data_t'(dAdr) ^ 16'hA5A5;
                end else begin
                    waits--;
                end
            end else begin
                busy = 1'b0;
            end
        end
    end

    initial begin
        reset = 1'b1;
        cycles = 0;
        retired = 0;
        loadStim();
        cycleLimit = 20 * expPc.size();
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        // Both buses idle and nothing retired as reset ends.
        checkStrobe("reset exit iCyc", 1'b0, iCyc);
        checkStrobe("reset exit dCyc", 1'b0, dCyc);
        checkStrobe("reset exit retireValid", 1'b0, retireValid);
        while (retired < expPc.size()) begin
            @(negedge clk);    // Retire outputs are registered.
            cycles++;
            if (cycles > cycleLimit) begin
                failRun($sformatf("timeout after %0d cycles, only %0d of %0d retirements seen",
                    cycles, retired, expPc.size()));
            end
            if (retireValid) begin
                checkPc($sformatf("retire %0d pc", retired), expPc[retired], retirePc);
                checkData($sformatf("retire %0d data", retired), expData[retired], retireData);
                retired++;
            end
        end
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== pipeTop.sv ====
module pipeTop (
    input  logic clk,
    input  logic reset,
    output instrPkg::pc_t iAdr,
    input  instrPkg::instr_t iDatIn,
    output logic iCyc,
    output logic iStb,
    input  logic iAck,
    output instrPkg::operand_t dAdr,
    input  instrPkg::data_t dDatIn,
    output logic dCyc,
    output logic dStb,
    input  logic dAck,
    output logic retireValid,
    output instrPkg::pc_t retirePc,
    output instrPkg::data_t retireData
);
    logic iWait, dWait, eWait;
    logic overflowI, branchM, excpM, excpW;
    logic redirectValid;
    instrPkg::pc_t redirectPc;
    logic fetchValid, issueValid;
    instrPkg::pc_t fetchPc, issuePc;
    instrPkg::instr_t fetchInstr, issueInstr;

    pipeCtrlIf ctrl ();

    hazard uHazard (
        .clk(clk), .reset(reset),
        .iWait(iWait), .dWait(dWait), .eWait(eWait), .overflowI(overflowI),
        .branchM(branchM), .excpM(excpM), .excpW(excpW),
        .ctrl(ctrl)
    );

    fetchUnit uFetch (
        .clk(clk), .reset(reset), .ctrl(ctrl),
        .redirectValid(redirectValid), .redirectPc(redirectPc),
        .iAdr(iAdr), .iDatIn(iDatIn), .iCyc(iCyc), .iStb(iStb), .iAck(iAck),
        .iWait(iWait),
        .fetchValid(fetchValid), .fetchPc(fetchPc), .fetchInstr(fetchInstr)
    );

    instrQueue uQueue (
        .clk(clk), .reset(reset), .ctrl(ctrl),
        .fetchValid(fetchValid), .fetchPc(fetchPc), .fetchInstr(fetchInstr),
        .overflowI(overflowI),
        .issueValid(issueValid), .issuePc(issuePc), .issueInstr(issueInstr)
    );

    execBackend uBack (
        .clk(clk), .reset(reset), .ctrl(ctrl),
        .issueValid(issueValid), .issuePc(issuePc), .issueInstr(issueInstr),
        .eWait(eWait), .dWait(dWait), .branchM(branchM), .excpM(excpM), .excpW(excpW),
        .redirectValid(redirectValid), .redirectPc(redirectPc),
        .dAdr(dAdr), .dDatIn(dDatIn), .dCyc(dCyc), .dStb(dStb), .dAck(dAck),
        .retireValid(retireValid), .retirePc(retirePc), .retireData(retireData)
    );

endmodule

// ==== pipe_defs.svh ====
`ifndef PIPE_DEFS_SVH
`define PIPE_DEFS_SVH

// Instruction address width in words.
`define PC_WIDTH 13
`define DATA_WIDTH 16

`define QUEUE_DEPTH 4    // Power of two.

`define RESET_PC 'h0
`define EXCP_VECTOR 'h100    // Target of every trap.

`endif

// ==== pipe_stim.txt ====
// M lines give an instruction memory address and its word in hex.
// R lines give the PC and data of each expected retirement in program order.
// Unlisted addresses read as ALU. Data is zero for anything but a load.
M 0004 2010
M 0010 6020
M 0011 61f3
M 0013 4003
M 0016 4008
M 0017 400a
M 0018 400f
M 0019 4009
M 001e 8000
M 0102 2040
M 0041 6155
M 0042 a000
// Straight run, then the branch to 0010.
R 0000 0000
R 0001 0000
R 0002 0000
R 0003 0000
R 0004 0000
// Two loads, a short multiply and a burst of long ones.
R 0010 a585
R 0011 a456
R 0012 0000
R 0013 0000
R 0014 0000
R 0015 0000
R 0016 0000
R 0017 0000
R 0018 0000
R 0019 0000
R 001a 0000
R 001b 0000
R 001c 0000
R 001d 0000
// TRAPM at 001e goes to the exception vector.
R 0100 0000
R 0101 0000
R 0102 0000
R 0040 0000
R 0041 a4f0
// TRAPW at 0042 goes back to the vector.
R 0100 0000
R 0101 0000
R 0102 0000
R 0040 0000

// ==== sources.f ====
+incdir+.
instrPkg.sv
ctrlPkg.sv
pipeCtrlIf.sv
hazard.sv
fetchUnit.sv
instrQueue.sv
execBackend.sv
pipeTop.sv
pipeTb.sv
